// File: src/afferent_mixer.sv
`default_nettype none

module afferent_mixer (
	input wire clk,
	input wire reset,
	input wire rates_ready,
	input wire spindle_pkg::rate_t ia_bag1,
	input wire spindle_pkg::rate_t ia_bag2,
	input wire spindle_pkg::rate_t ia_chain,
	input wire spindle_pkg::rate_t ii_bag2,
	input wire spindle_pkg::rate_t ii_chain,
	output spindle_pkg::rate_t ia_muscle,
	output spindle_pkg::rate_t ii_muscle,
	output logic valid
);

	spindle_pkg::rate_t ia_b2c;
	spindle_pkg::rate_t ia_larger;
	spindle_pkg::rate_t ia_smaller;
	spindle_pkg::rate_t ia_partial;

	function automatic spindle_pkg::rate_t sat_rate(input logic [32:0] sum);
		if (sum > spindle_pkg::RATE_MAX) return spindle_pkg::RATE_MAX;
		return spindle_pkg::rate_t'(sum[31:0]);
	endfunction

	assign ia_b2c = sat_rate(ia_bag2 + ia_chain);

	// occlusion between bag1 and bag2 + chain
	assign ia_larger = (ia_bag1 >= ia_b2c) ? ia_bag1 : ia_b2c;
	assign ia_smaller = (ia_bag1 >= ia_b2c) ? ia_b2c : ia_bag1;
	assign ia_partial = spindle_pkg::rate_t'(spindle_pkg::fix_mul(
		spindle_pkg::len_t'(ia_smaller), spindle_pkg::MIX_PARTIAL));

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ia_muscle <= '0;
			ii_muscle <= '0;
			valid <= 1'b0;
		end else begin
			valid <= rates_ready;
			if (rates_ready) begin
				ia_muscle <= sat_rate(ia_larger + ia_partial);
				ii_muscle <= sat_rate(ii_bag2 + ii_chain);
			end
		end
	end

endmodule

`default_nettype wire

// File: src/afferent_primary.sv
`default_nettype none

module afferent_primary (
	input wire clk,
	input wire reset,
	input wire frame_done,
	input wire spindle_pkg::len_t lce,
	input wire spindle_pkg::gain_t gain_i,
	input wire spindle_pkg::len_t stretch_bag1,
	input wire spindle_pkg::len_t stretch_bag2,
	input wire spindle_pkg::len_t stretch_chain,
	output spindle_pkg::rate_t ia_bag1,
	output spindle_pkg::rate_t ia_bag2,
	output spindle_pkg::rate_t ia_chain,
	output logic rates_ready
);

	spindle_pkg::rate_t ia_bag1_next;
	spindle_pkg::rate_t ia_bag2_next;
	spindle_pkg::rate_t ia_chain_next;

	// Ia follows the sensory region stretch
	assign ia_bag1_next = spindle_pkg::rate_from_len(gain_i,
		lce - stretch_bag1 - spindle_pkg::LSR0);
	assign ia_bag2_next = spindle_pkg::rate_from_len(gain_i,
		lce - stretch_bag2 - spindle_pkg::LSR0);
	assign ia_chain_next = spindle_pkg::rate_from_len(gain_i,
		lce - stretch_chain - spindle_pkg::LSR0);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ia_bag1 <= '0;
			ia_bag2 <= '0;
			ia_chain <= '0;
			rates_ready <= 1'b0;
		end else begin
			rates_ready <= frame_done;
			if (frame_done) begin
				ia_bag1 <= ia_bag1_next;
				ia_bag2 <= ia_bag2_next;
				ia_chain <= ia_chain_next;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/afferent_secondary.sv
`default_nettype none

module afferent_secondary (
	input wire clk,
	input wire reset,
	input wire frame_done,
	input wire spindle_pkg::len_t lce,
	input wire spindle_pkg::gain_t gain_ii,
	input wire spindle_pkg::len_t stretch_bag2,
	input wire spindle_pkg::len_t stretch_chain,
	output spindle_pkg::rate_t ii_bag2,
	output spindle_pkg::rate_t ii_chain
);

	spindle_pkg::len_t l_bag2;
	spindle_pkg::len_t l_chain;
	spindle_pkg::rate_t ii_bag2_next;
	spindle_pkg::rate_t ii_chain_next;

	// sensory share plus polar share of the fiber length
	function automatic spindle_pkg::len_t ii_weighted(input spindle_pkg::len_t l_sens,
		input spindle_pkg::len_t l_total);
		spindle_pkg::len_t polar;
		polar = l_total - l_sens - spindle_pkg::II_REST_SUM;
		return spindle_pkg::fix_mul(spindle_pkg::II_SENS_FRAC, l_sens)
			+ spindle_pkg::fix_mul(spindle_pkg::II_POLAR_FRAC, polar);
	endfunction

	assign l_bag2 = lce - stretch_bag2 - spindle_pkg::LSR0;
	assign l_chain = lce - stretch_chain - spindle_pkg::LSR0;

	assign ii_bag2_next = spindle_pkg::rate_from_len(gain_ii, ii_weighted(l_bag2, lce));
	assign ii_chain_next = spindle_pkg::rate_from_len(gain_ii, ii_weighted(l_chain, lce));

	// same edge as the primary encoder
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ii_bag2 <= '0;
			ii_chain <= '0;
		end else if (frame_done) begin
			ii_bag2 <= ii_bag2_next;
			ii_chain <= ii_chain_next;
		end
	end

endmodule

`default_nettype wire

// File: src/fiber_dynamics.sv
`default_nettype none

module fiber_dynamics #(
	parameter int DT_SHIFT = 12
) (
	input wire clk,
	input wire reset,
	input wire spindle_pkg::drive_t gamma_dyn,
	input wire spindle_pkg::drive_t gamma_sta,
	input wire spindle_pkg::len_t lce,
	input wire spindle_pkg::len_t bdamp_1,
	input wire spindle_pkg::len_t bdamp_2,
	input wire spindle_pkg::len_t bdamp_chain,
	output spindle_pkg::len_t stretch_bag1,
	output spindle_pkg::len_t stretch_bag2,
	output spindle_pkg::len_t stretch_chain,
	output logic frame_done
);

	spindle_pkg::phase_t phase;
	spindle_pkg::phase_t phase_next;

	// fiber states: activation, stretch, stretch velocity
	spindle_pkg::len_t x0_bag1, x1_bag1, x2_bag1;
	spindle_pkg::len_t x0_bag2, x1_bag2, x2_bag2;
	spindle_pkg::len_t x0_chain, x1_chain, x2_chain;

	spindle_pkg::len_t x_0_sel, x_1_sel, x_2_sel;
	spindle_pkg::len_t dx_0, dx_1, dx_2;
	spindle_pkg::len_t nx_0, nx_1, nx_2;

	function automatic spindle_pkg::len_t sat_add(input spindle_pkg::len_t a,
		input spindle_pkg::len_t b);
		logic signed [32:0] s;
		s = a + b;
		if (s[32] != s[31]) return s[32] ? spindle_pkg::LEN_MIN : spindle_pkg::LEN_MAX;
		return spindle_pkg::len_t'(s[31:0]);
	endfunction

	always_comb begin
		case (phase)
			spindle_pkg::ph_bag1: phase_next = spindle_pkg::ph_bag2;
			spindle_pkg::ph_bag2: phase_next = spindle_pkg::ph_chain;
			default: phase_next = spindle_pkg::ph_bag1;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			phase <= spindle_pkg::ph_bag1;
		else
			phase <= phase_next;
	end

	// fiber selected for this cycle
	always_comb begin
		case (phase)
			spindle_pkg::ph_bag1: begin
				x_0_sel = x0_bag1;
				x_1_sel = x1_bag1;
				x_2_sel = x2_bag1;
			end
			spindle_pkg::ph_bag2: begin
				x_0_sel = x0_bag2;
				x_1_sel = x1_bag2;
				x_2_sel = x2_bag2;
			end
			default: begin
				x_0_sel = x0_chain;
				x_1_sel = x1_chain;
				x_2_sel = x2_chain;
			end
		endcase
	end

	spindle_derivatives derivatives_i (
		.phase(phase),
		.gamma_dyn(gamma_dyn),
		.gamma_sta(gamma_sta),
		.lce(lce),
		.x_0(x_0_sel),
		.x_1(x_1_sel),
		.x_2(x_2_sel),
		.bdamp_1(bdamp_1),
		.bdamp_2(bdamp_2),
		.bdamp_chain(bdamp_chain),
		.dx_0(dx_0),
		.dx_1(dx_1),
		.dx_2(dx_2)
	);

	// euler step, dt = 2^-DT_SHIFT s
	assign nx_0 = sat_add(x_0_sel, dx_0 >>> DT_SHIFT);
	assign nx_1 = sat_add(x_1_sel, dx_1 >>> DT_SHIFT);
	assign nx_2 = sat_add(x_2_sel, dx_2 >>> DT_SHIFT);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			x0_bag1 <= '0;
			x1_bag1 <= spindle_pkg::X1_RESET;
			x2_bag1 <= '0;
			x0_bag2 <= '0;
			x1_bag2 <= spindle_pkg::X1_RESET;
			x2_bag2 <= '0;
			x0_chain <= '0;
			x1_chain <= spindle_pkg::X1_RESET;
			x2_chain <= '0;
		end else begin
			case (phase)
				spindle_pkg::ph_bag1: begin
					x0_bag1 <= nx_0;
					x1_bag1 <= nx_1;
					x2_bag1 <= nx_2;
				end
				spindle_pkg::ph_bag2: begin
					x0_bag2 <= nx_0;
					x1_bag2 <= nx_1;
					x2_bag2 <= nx_2;
				end
				default: begin
					x0_chain <= nx_0;
					x1_chain <= nx_1;
					x2_chain <= nx_2;
				end
			endcase
		end
	end

	// snapshot taken with the chain update, so the whole frame is coherent
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			stretch_bag1 <= '0;
			stretch_bag2 <= '0;
			stretch_chain <= '0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= (phase == spindle_pkg::ph_chain);
			if (phase == spindle_pkg::ph_chain) begin
				stretch_bag1 <= x1_bag1;
				stretch_bag2 <= x1_bag2;
				stretch_chain <= nx_1;  // chain result of this edge
			end
		end
	end

endmodule

`default_nettype wire

// File: src/spindle_derivatives.sv
`default_nettype none

module spindle_derivatives (
	input wire spindle_pkg::phase_t phase,
	input wire spindle_pkg::drive_t gamma_dyn,
	input wire spindle_pkg::drive_t gamma_sta,
	input wire spindle_pkg::len_t lce,
	input wire spindle_pkg::len_t x_0,
	input wire spindle_pkg::len_t x_1,
	input wire spindle_pkg::len_t x_2,
	input wire spindle_pkg::len_t bdamp_1,
	input wire spindle_pkg::len_t bdamp_2,
	input wire spindle_pkg::len_t bdamp_chain,
	output spindle_pkg::len_t dx_0,
	output spindle_pkg::len_t dx_1,
	output spindle_pkg::len_t dx_2
);

	spindle_pkg::drive_t gamma;
	spindle_pkg::len_t bdamp;
	spindle_pkg::len_t k_sum;
	spindle_pkg::len_t tau_inv;
	logic [31:0] fs_sqr;
	logic [31:0] gamma_sqr;
	logic [32:0] act_den;
	spindle_pkg::len_t act_target;
	spindle_pkg::len_t act;
	spindle_pkg::len_t damp_mag;
	spindle_pkg::len_t damp;
	logic signed [34:0] force_wide;
	spindle_pkg::len_t force_sat;

	// per fiber drive and constants
	always_comb begin
		case (phase)
			spindle_pkg::ph_bag1: begin
				gamma = gamma_dyn;
				bdamp = bdamp_1;
				k_sum = spindle_pkg::K_SUM_BAG1;
				tau_inv = spindle_pkg::TAU_INV_BAG1;
				fs_sqr = spindle_pkg::FS_SQR_BAG1;
			end
			spindle_pkg::ph_bag2: begin
				gamma = gamma_sta;
				bdamp = bdamp_2;
				k_sum = spindle_pkg::K_SUM_BAG2;
				tau_inv = spindle_pkg::TAU_INV_BAG2;
				fs_sqr = spindle_pkg::FS_SQR_BAG2;
			end
			default: begin  // chain
				gamma = gamma_sta;
				bdamp = bdamp_chain;
				k_sum = spindle_pkg::K_SUM_CHAIN;
				tau_inv = '0;
				fs_sqr = spindle_pkg::FS_SQR_CHAIN;
			end
		endcase
	end

	// activation target g^2 / (g^2 + fs^2), both terms scaled down by 4 to fit
	assign gamma_sqr = gamma * gamma;
	assign act_den = gamma_sqr + fs_sqr;
	assign act_target = spindle_pkg::fix_div(spindle_pkg::len_t'(gamma_sqr >> 2),
		spindle_pkg::len_t'(act_den >> 2));

	// chain follows its target with no lag
	assign act = (phase == spindle_pkg::ph_chain) ? act_target : x_0;
	assign dx_0 = (phase == spindle_pkg::ph_chain) ? '0 :
		spindle_pkg::fix_mul(act_target - x_0, tau_inv);

	assign dx_1 = x_2;

	// copysign(1, x_2) * bdamp * activation
	assign damp_mag = spindle_pkg::fix_mul(bdamp, act);
	assign damp = x_2[31] ? -damp_mag : damp_mag;

	assign force_wide = spindle_pkg::fix_mul(spindle_pkg::KSR, lce)
		- spindle_pkg::fix_mul(k_sum, x_1) - damp - spindle_pkg::OFFSET_F;
	assign force_sat = (force_wide > spindle_pkg::LEN_MAX) ? spindle_pkg::LEN_MAX :
		(force_wide < spindle_pkg::LEN_MIN) ? spindle_pkg::LEN_MIN :
		spindle_pkg::len_t'(force_wide[31:0]);

	assign dx_2 = spindle_pkg::fix_div(force_sat, spindle_pkg::MASS);  // force / mass

endmodule

`default_nettype wire

// File: src/spindle_pkg.sv
`default_nettype none

package spindle_pkg;

	typedef logic signed [31:0] len_t;   // Q8.24
	typedef logic [31:0] gain_t;         // Q16.16
	typedef logic [15:0] drive_t;        // pulses per second
	typedef logic [31:0] rate_t;         // Q24.8

	typedef enum logic [1:0] {
		ph_bag1,
		ph_bag2,
		ph_chain
	} phase_t;

	localparam len_t LEN_MAX = 32'sh7fff_ffff;
	localparam len_t LEN_MIN = 32'sh8000_0000;

	localparam rate_t RATE_MAX = 32'd25600000;  // 100000 pps

	// sensory region and secondary encoder weights
	localparam len_t LSR0 = 32'sd671089;            // 0.04
	localparam len_t II_SENS_FRAC = 32'sd11744051;  // 0.7
	localparam len_t II_POLAR_FRAC = 32'sd264912;   // 0.01579
	localparam len_t II_REST_SUM = 32'sd16106127;   // 0.96
	localparam len_t MIX_PARTIAL = 32'sd2617246;    // 0.156

	localparam len_t X1_RESET = 32'sd16070895;      // 0.9579

	// fiber mechanics, common to all fibers
	localparam len_t KSR = 32'sd175571888;     // 10.4649
	localparam len_t MASS = 32'sd3355;         // 0.0002
	localparam len_t OFFSET_F = 32'sd6710886;  // 0.4

	// per fiber: ksr + kpr
	localparam len_t K_SUM_BAG1 = 32'sd177462680;   // 10.5776
	localparam len_t K_SUM_BAG2 = 32'sd178294830;   // 10.6272
	localparam len_t K_SUM_CHAIN = 32'sd178294830;

	// activation time constant reciprocals, chain has none
	localparam len_t TAU_INV_BAG1 = 32'sd112591897;  // 6.711
	localparam len_t TAU_INV_BAG2 = 32'sd81839260;   // 4.878

	// frequency squared, in drive squared units
	localparam logic [31:0] FS_SQR_BAG1 = 32'd3600;
	localparam logic [31:0] FS_SQR_BAG2 = 32'd3600;
	localparam logic [31:0] FS_SQR_CHAIN = 32'd8100;

	function automatic len_t fix_mul(input len_t a, input len_t b);
		logic signed [63:0] p;
		logic signed [63:0] s;
		p = a * b;
		s = p >>> 24;
		if (s > LEN_MAX) return LEN_MAX;
		if (s < LEN_MIN) return LEN_MIN;
		return len_t'(s[31:0]);
	endfunction

	function automatic len_t fix_div(input len_t a, input len_t b);
		logic signed [63:0] n;
		logic signed [63:0] q;
		if (b == 0) return (a < 0) ? LEN_MIN : LEN_MAX;
		n = a;
		n = n <<< 24;
		q = n / b;
		if (q > LEN_MAX) return LEN_MAX;
		if (q < LEN_MIN) return LEN_MIN;
		return len_t'(q[31:0]);
	endfunction

	// gain times length, scaled to pps and clamped to [0, RATE_MAX]
	function automatic rate_t rate_from_len(input gain_t g, input len_t l);
		logic [63:0] p;
		logic [63:0] r;
		if (l <= 0) return '0;
		p = g * $unsigned(l);
		r = p >> 32;  // Q.40 down to Q.8
		if (r > RATE_MAX) return RATE_MAX;
		return rate_t'(r[31:0]);
	endfunction

endpackage

`default_nettype wire

// File: src/spindle_top.sv
`default_nettype none

module spindle_top #(
	parameter int DT_SHIFT = 12  // euler step 2^-DT_SHIFT s
) (
	input wire clk,
	input wire reset,
	input wire spindle_pkg::len_t lce,
	input wire spindle_pkg::drive_t gamma_dyn,
	input wire spindle_pkg::drive_t gamma_sta,
	input wire spindle_pkg::gain_t gain_i,
	input wire spindle_pkg::gain_t gain_ii,
	input wire spindle_pkg::len_t bdamp_1,
	input wire spindle_pkg::len_t bdamp_2,
	input wire spindle_pkg::len_t bdamp_chain,
	output wire spindle_pkg::len_t stretch_bag1,
	output wire spindle_pkg::len_t stretch_bag2,
	output wire spindle_pkg::len_t stretch_chain,
	output wire spindle_pkg::rate_t ia_bag1,
	output wire spindle_pkg::rate_t ia_bag2,
	output wire spindle_pkg::rate_t ia_chain,
	output wire spindle_pkg::rate_t ii_bag2,
	output wire spindle_pkg::rate_t ii_chain,
	output wire spindle_pkg::rate_t ia_muscle,
	output wire spindle_pkg::rate_t ii_muscle,
	output wire valid
);

	wire frame_done;
	wire rates_ready;

	fiber_dynamics #(
		.DT_SHIFT(DT_SHIFT)
	) fiber_dynamics_i (
		.clk(clk),
		.reset(reset),
		.gamma_dyn(gamma_dyn),
		.gamma_sta(gamma_sta),
		.lce(lce),
		.bdamp_1(bdamp_1),
		.bdamp_2(bdamp_2),
		.bdamp_chain(bdamp_chain),
		.stretch_bag1(stretch_bag1),
		.stretch_bag2(stretch_bag2),
		.stretch_chain(stretch_chain),
		.frame_done(frame_done)
	);

	// both encoders fire on frame_done
	afferent_primary afferent_primary_i (
		.clk(clk),
		.reset(reset),
		.frame_done(frame_done),
		.lce(lce),
		.gain_i(gain_i),
		.stretch_bag1(stretch_bag1),
		.stretch_bag2(stretch_bag2),
		.stretch_chain(stretch_chain),
		.ia_bag1(ia_bag1),
		.ia_bag2(ia_bag2),
		.ia_chain(ia_chain),
		.rates_ready(rates_ready)
	);

	afferent_secondary afferent_secondary_i (
		.clk(clk),
		.reset(reset),
		.frame_done(frame_done),
		.lce(lce),
		.gain_ii(gain_ii),
		.stretch_bag2(stretch_bag2),
		.stretch_chain(stretch_chain),
		.ii_bag2(ii_bag2),
		.ii_chain(ii_chain)
	);

	afferent_mixer afferent_mixer_i (
		.clk(clk),
		.reset(reset),
		.rates_ready(rates_ready),
		.ia_bag1(ia_bag1),
		.ia_bag2(ia_bag2),
		.ia_chain(ia_chain),
		.ii_bag2(ii_bag2),
		.ii_chain(ii_chain),
		.ia_muscle(ia_muscle),
		.ii_muscle(ii_muscle),
		.valid(valid)
	);

endmodule

`default_nettype wire

// File: tb.f
+incdir+verification
src/spindle_pkg.sv
src/spindle_derivatives.sv
src/fiber_dynamics.sv
src/afferent_primary.sv
src/afferent_secondary.sv
src/afferent_mixer.sv
src/spindle_top.sv
verification/spindle_tb.sv

// File: verification/spindle_checks.svh
`ifndef SPINDLE_CHECKS_SVH
`define SPINDLE_CHECKS_SVH

task automatic check_len(input string name, input spindle_pkg::len_t exp,
	input spindle_pkg::len_t act);
	if (exp !== act) begin
		$display("CHECK FAILED %s expected %0d actual %0d", name, exp, act);
		$display("** FAIL **");
		$fatal(1, "stretch mismatch");
	end
endtask

task automatic check_rate(input string name, input spindle_pkg::rate_t exp,
	input spindle_pkg::rate_t act);
	if (exp !== act) begin
		$display("CHECK FAILED %s expected %0d actual %0d", name, exp, act);
		$display("** FAIL **");
		$fatal(1, "rate mismatch");
	end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
	if (exp !== act) begin
		$display("CHECK FAILED %s expected %0b actual %0b", name, exp, act);
		$display("** FAIL **");
		$fatal(1, "flag mismatch");
	end
endtask

// Q16.16 gain times Q8.24 length is Q24.40, keep Q24.8
function automatic spindle_pkg::rate_t expect_rate(input spindle_pkg::gain_t g,
	input spindle_pkg::len_t l);
	logic [63:0] wide;
	if (l <= 0)
		return '0;
	wide = {32'b0, g} * {32'b0, l};
	wide = wide >> 32;
	if (wide > spindle_pkg::RATE_MAX)
		return spindle_pkg::RATE_MAX;
	return wide[31:0];
endfunction

function automatic spindle_pkg::len_t sensory_len(input spindle_pkg::len_t lce,
	input spindle_pkg::len_t stretch);
	return lce - stretch - spindle_pkg::LSR0;
endfunction

function automatic spindle_pkg::rate_t expect_primary(input spindle_pkg::gain_t g,
	input spindle_pkg::len_t lce, input spindle_pkg::len_t stretch);
	return expect_rate(g, sensory_len(lce, stretch));
endfunction

// 0.7 * L + 0.01579 * (lce - L - 0.96)
function automatic spindle_pkg::rate_t expect_secondary(input spindle_pkg::gain_t g,
	input spindle_pkg::len_t lce, input spindle_pkg::len_t stretch);
	logic signed [63:0] l_sens;
	logic signed [63:0] l_polar;
	logic signed [63:0] w_sens;
	logic signed [63:0] w_polar;
	spindle_pkg::len_t sum;
	l_sens = sensory_len(lce, stretch);
	l_polar = spindle_pkg::len_t'(lce - sensory_len(lce, stretch) - spindle_pkg::II_REST_SUM);
	w_sens = (l_sens * 64'sd11744051) >>> 24;
	w_polar = (l_polar * 64'sd264912) >>> 24;
	sum = w_sens[31:0] + w_polar[31:0];
	return expect_rate(g, sum);
endfunction

`endif

// File: verification/spindle_tb.sv
`default_nettype none

module spindle_tb;

	timeunit 1ns;
	timeprecision 100ps;

	`include "spindle_checks.svh"

	localparam int N_ROWS = 6;

	logic clk;
	logic reset;
	spindle_pkg::len_t lce;
	spindle_pkg::drive_t gamma_dyn;
	spindle_pkg::drive_t gamma_sta;
	spindle_pkg::gain_t gain_i;
	spindle_pkg::gain_t gain_ii;
	spindle_pkg::len_t bdamp_1;
	spindle_pkg::len_t bdamp_2;
	spindle_pkg::len_t bdamp_chain;
	wire spindle_pkg::len_t stretch_bag1;
	wire spindle_pkg::len_t stretch_bag2;
	wire spindle_pkg::len_t stretch_chain;
	wire spindle_pkg::rate_t ia_bag1;
	wire spindle_pkg::rate_t ia_bag2;
	wire spindle_pkg::rate_t ia_chain;
	wire spindle_pkg::rate_t ii_bag2;
	wire spindle_pkg::rate_t ii_chain;
	wire spindle_pkg::rate_t ia_muscle;
	wire spindle_pkg::rate_t ii_muscle;
	wire valid;

	// stimulus table with one entry per row
	string row_name [N_ROWS];
	spindle_pkg::len_t row_lce_lo [N_ROWS];
	spindle_pkg::len_t row_lce_hi [N_ROWS];
	spindle_pkg::drive_t row_gdyn [N_ROWS];
	spindle_pkg::drive_t row_gsta [N_ROWS];
	spindle_pkg::gain_t row_gi [N_ROWS];
	spindle_pkg::gain_t row_gii [N_ROWS];
	spindle_pkg::len_t row_b1 [N_ROWS];
	spindle_pkg::len_t row_b2 [N_ROWS];
	spindle_pkg::len_t row_bc [N_ROWS];
	int row_frames [N_ROWS];
	bit row_dyn [N_ROWS];    // stretch must move away from X1_RESET
	bit row_zero [N_ROWS];   // first frame gives zero rates
	bit row_clamp [N_ROWS];  // first frame saturates

	int cycles_since_release;
	int cycle_count;
	int cycle_limit;
	int bag1_wins;
	int b2c_wins;

	spindle_top spindle_top_i (
		.clk(clk),
		.reset(reset),
		.lce(lce),
		.gamma_dyn(gamma_dyn),
		.gamma_sta(gamma_sta),
		.gain_i(gain_i),
		.gain_ii(gain_ii),
		.bdamp_1(bdamp_1),
		.bdamp_2(bdamp_2),
		.bdamp_chain(bdamp_chain),
		.stretch_bag1(stretch_bag1),
		.stretch_bag2(stretch_bag2),
		.stretch_chain(stretch_chain),
		.ia_bag1(ia_bag1),
		.ia_bag2(ia_bag2),
		.ia_chain(ia_chain),
		.ii_bag2(ii_bag2),
		.ii_chain(ii_chain),
		.ia_muscle(ia_muscle),
		.ii_muscle(ii_muscle),
		.valid(valid)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic set_row(input int i, input string name, input spindle_pkg::len_t lo,
		input spindle_pkg::len_t hi, input spindle_pkg::drive_t gd,
		input spindle_pkg::drive_t gs, input spindle_pkg::gain_t gi,
		input spindle_pkg::gain_t gii, input spindle_pkg::len_t b1,
		input spindle_pkg::len_t b2, input spindle_pkg::len_t bc, input int frames,
		input bit dyn, input bit zero, input bit clamp);
		row_name[i] = name;
		row_lce_lo[i] = lo;
		row_lce_hi[i] = hi;
		row_gdyn[i] = gd;
		row_gsta[i] = gs;
		row_gi[i] = gi;
		row_gii[i] = gii;
		row_b1[i] = b1;
		row_b2[i] = b2;
		row_bc[i] = bc;
		row_frames[i] = frames;
		row_dyn[i] = dyn;
		row_zero[i] = zero;
		row_clamp[i] = clamp;
	endtask

	task automatic load_table();
		// lengths in Q8.24 and gains in Q16.16
		set_row(0, "dynamics", 32'sd19797115, 32'sd20468204, 16'd100, 16'd60,
			32'd131072000, 32'd131072000, 32'sd8388608, 32'sd3355443, 32'sd0, 20, 1, 0, 0);
		set_row(1, "below_rest", 32'sd3355443, 32'sd3355443, 16'd100, 16'd60,
			32'd131072000, 32'd131072000, 32'sd8388608, 32'sd3355443, 32'sd0, 2, 0, 1, 0);
		set_row(2, "clamp", 32'sd83886080, 32'sd83886080, 16'd100, 16'd60,
			32'hffff_0000, 32'hffff_0000, 32'sd0, 32'sd0, 32'sd0, 2, 0, 0, 1);
		set_row(3, "bag1_heavy", 32'sd21810381, 32'sd23488102, 16'd250, 16'd20,
			32'd131072000, 32'd65536000, 32'sd33554432, 32'sd0, 32'sd0, 15, 0, 0, 0);
		set_row(4, "b2c_heavy", 32'sd16777216, 32'sd18454938, 16'd10, 16'd200,
			32'd131072000, 32'd65536000, 32'sd0, 32'sd33554432, 32'sd33554432, 15, 0, 0, 0);
		set_row(5, "sweep", 32'sd15099494, 32'sd25165824, 16'd80, 16'd80,
			32'd131072000, 32'd65536000, 32'sd5033165, 32'sd5033165, 32'sd5033165, 20, 0, 0, 0);
	endtask

	task automatic drive_row(input int i);
		logic [31:0] span;
		span = row_lce_hi[i] - row_lce_lo[i];
		if (span == 0)
			lce = row_lce_lo[i];
		else
			lce = row_lce_lo[i] + ($urandom % (span + 1));
		gamma_dyn = row_gdyn[i];
		gamma_sta = row_gsta[i];
		gain_i = row_gi[i];
		gain_ii = row_gii[i];
		bdamp_1 = row_b1[i];
		bdamp_2 = row_b2[i];
		bdamp_chain = row_bc[i];
	endtask

	// one clock, then valid must come at 5 and every 3 after
	task automatic step_cycle();
		logic exp_valid;
		@(posedge clk);
		#1;
		cycles_since_release++;
		exp_valid = (cycles_since_release >= 5) && ((cycles_since_release - 5) % 3 == 0);
		check_bit("valid cadence", exp_valid, valid);
	endtask

	task automatic wait_valid();
		step_cycle();
		while (valid !== 1'b1)
			step_cycle();
	endtask

	task automatic check_frame(input string name);
		spindle_pkg::rate_t b2c;
		spindle_pkg::rate_t larger;
		spindle_pkg::rate_t smaller;
		logic [63:0] partial;
		logic [32:0] sum;
		check_rate({name, " ia_bag1"}, expect_primary(gain_i, lce, stretch_bag1), ia_bag1);
		check_rate({name, " ia_bag2"}, expect_primary(gain_i, lce, stretch_bag2), ia_bag2);
		check_rate({name, " ia_chain"}, expect_primary(gain_i, lce, stretch_chain), ia_chain);
		check_rate({name, " ii_bag2"}, expect_secondary(gain_ii, lce, stretch_bag2), ii_bag2);
		check_rate({name, " ii_chain"}, expect_secondary(gain_ii, lce, stretch_chain),
			ii_chain);
		// larger of bag1 and bag2 + chain plus 0.156 of the smaller
		sum = ia_bag2 + ia_chain;
		b2c = (sum > spindle_pkg::RATE_MAX) ? spindle_pkg::RATE_MAX : sum[31:0];
		if (ia_bag1 >= b2c) begin
			larger = ia_bag1;
			smaller = b2c;
			bag1_wins++;
		end else begin
			larger = b2c;
			smaller = ia_bag1;
			b2c_wins++;
		end
		partial = ({32'b0, smaller} * 64'd2617246) >> 24;
		sum = larger + partial[31:0];
		check_rate({name, " ia_muscle"},
			(sum > spindle_pkg::RATE_MAX) ? spindle_pkg::RATE_MAX : sum[31:0], ia_muscle);
		sum = ii_bag2 + ii_chain;
		check_rate({name, " ii_muscle"},
			(sum > spindle_pkg::RATE_MAX) ? spindle_pkg::RATE_MAX : sum[31:0], ii_muscle);
	endtask

	task automatic check_direction(input string name, input spindle_pkg::len_t s);
		logic rising;
		rising = (lce - spindle_pkg::X1_RESET - spindle_pkg::LSR0) > 0;
		check_bit({name, " moved"}, 1'b1, s != spindle_pkg::X1_RESET);
		check_bit({name, " direction"}, rising, s > spindle_pkg::X1_RESET);
	endtask

	// run limit from the table length
	initial begin
		cycle_count = 0;
		#1;
		forever begin
			@(posedge clk);
			cycle_count++;
			if (cycle_count > cycle_limit) begin
				$display("timeout: valid frames stopped arriving after %0d cycles", cycle_count);
				$display("** FAIL **");
				$fatal(1, "timeout");
			end
		end
	end

	initial begin
		int total;
		void'($urandom(48));
		load_table();
		total = 0;
		for (int i = 0; i < N_ROWS; i++)
			total += row_frames[i];
		cycle_limit = total * 3 + 50;
		cycles_since_release = 0;
		bag1_wins = 0;
		b2c_wins = 0;
		reset = 1'b1;
		drive_row(0);

		// outputs held at zero during reset
		repeat (10) begin
			@(posedge clk);
			#1;
			check_bit("reset valid", 1'b0, valid);
			check_len("reset stretch_bag1", '0, stretch_bag1);
			check_len("reset stretch_bag2", '0, stretch_bag2);
			check_len("reset stretch_chain", '0, stretch_chain);
			check_rate("reset ia_muscle", '0, ia_muscle);
			check_rate("reset ii_muscle", '0, ii_muscle);
			check_rate("reset ia_bag1", '0, ia_bag1);
			check_rate("reset ia_bag2", '0, ia_bag2);
			check_rate("reset ia_chain", '0, ia_chain);
			check_rate("reset ii_bag2", '0, ii_bag2);
			check_rate("reset ii_chain", '0, ii_chain);
		end
		reset = 1'b0;

		for (int r = 0; r < N_ROWS; r++) begin
			for (int f = 0; f < row_frames[r]; f++) begin
				wait_valid();
				check_frame(row_name[r]);
				if (f == 0 && row_zero[r]) begin
					check_rate({row_name[r], " zero ia_bag1"}, '0, ia_bag1);
					check_rate({row_name[r], " zero ii_bag2"}, '0, ii_bag2);
				end
				if (f == 0 && row_clamp[r]) begin
					check_rate({row_name[r], " max ia_bag1"}, spindle_pkg::RATE_MAX, ia_bag1);
					check_rate({row_name[r], " max ii_bag2"}, spindle_pkg::RATE_MAX, ii_bag2);
				end
				if (f == row_frames[r] - 1 && row_dyn[r]) begin
					check_direction("stretch_bag1", stretch_bag1);
					check_direction("stretch_bag2", stretch_bag2);
					check_direction("stretch_chain", stretch_chain);
				end
				// next inputs take effect from the next frame
				if (f == row_frames[r] - 1 && r < N_ROWS - 1)
					drive_row(r + 1);
				else
					drive_row(r);
			end
		end

		// both occlusion branches seen over the table
		check_bit("occlusion bag1 larger seen", 1'b1, bag1_wins > 0);
		check_bit("occlusion bag2+chain larger seen", 1'b1, b2c_wins > 0);
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire
